// ==== hw/trap_pkg.sv ====
// Machine-mode trap definitions
package trap_pkg;

    // Machine word.
    typedef logic [31:0] xlen_t;

    // Interrupt or trap number, as held in mcause.
    typedef logic [4:0] irq_cause_t;

    // Machine information and trap setup CSRs.
    localparam logic [11:0] CSR_MSTATUS    = 12'h300;
    localparam logic [11:0] CSR_MISA       = 12'h301;
    localparam logic [11:0] CSR_MEDELEG    = 12'h302;
    localparam logic [11:0] CSR_MIDELEG    = 12'h303;
    localparam logic [11:0] CSR_MIE        = 12'h304;
    localparam logic [11:0] CSR_MTVEC      = 12'h305;
    localparam logic [11:0] CSR_MSTATUSH   = 12'h310;

    // Trap handling CSRs.
    localparam logic [11:0] CSR_MSCRATCH   = 12'h340;
    localparam logic [11:0] CSR_MEPC       = 12'h341;
    localparam logic [11:0] CSR_MCAUSE     = 12'h342;
    localparam logic [11:0] CSR_MTVAL      = 12'h343;
    localparam logic [11:0] CSR_MIP        = 12'h344;

    // Read-only identification CSRs.
    localparam logic [11:0] CSR_MVENDORID  = 12'hf11;
    localparam logic [11:0] CSR_MARCHID    = 12'hf12;
    localparam logic [11:0] CSR_MIPID      = 12'hf13;
    localparam logic [11:0] CSR_MHARTID    = 12'hf14;
    localparam logic [11:0] CSR_MCONFIGPTR = 12'hf15;

    // Architecture ID of this core family.
    localparam xlen_t ARCH_ID = 32'd37;
    // Version 1.4.0 in the low half, divider latency 2 in bits 21:16.
    localparam xlen_t IMPL_ID = 32'h0002_0140;

    // Extensions the hardware can run.
    localparam bit HAS_M = 1'b1;
    localparam bit HAS_C = 1'b1;

    // Cycles mstatus.MIE must have been set before interrupts are taken.
    localparam int MIE_DELAY = 2;
    // Interrupt number of the machine timer line.
    localparam int TIMER_IRQ = 7;

    // One CSR word seen through the register layouts.
    typedef union packed {
        xlen_t raw;
        struct packed {
            logic [23:0] rsvd_hi;
            logic        mpie;
            logic [2:0]  rsvd_mid;
            logic        mie;
            logic [2:0]  rsvd_lo;
        } mstatus;
        struct packed {
            logic [1:0]  mxl;
            logic [16:0] rsvd_hi;
            logic        m;
            logic [2:0]  rsvd_jl;
            logic        i;
            logic [4:0]  rsvd_dh;
            logic        c;
            logic        b;
            logic        a;
        } misa;
        struct packed {
            logic        intr;
            logic [25:0] rsvd;
            irq_cause_t  code;
        } mcause;
    } csr_word_u;

endpackage

// ==== hw/csr_access_if.sv ====
// CSR access port
`timescale 1ns/1ps

interface csr_access_if
    import trap_pkg::*;
();
    // CSR address.
    logic [11:0] addr;
    // Write strobe, applied on the next rising edge.
    logic        we;
    // Write data.
    xlen_t       wdata;
    // Read data, combinational from addr.
    xlen_t       rdata;
    // Address is an implemented CSR.
    logic        exists;
    // Address is a read-only CSR.
    logic        rdonly;

    // Requester side.
    modport host (
        output addr, we, wdata,
        input  rdata, exists, rdonly
    );

    // Register file side.
    modport file (
        input  addr, we, wdata,
        output rdata, exists, rdonly
    );

endinterface

// ==== hw/trap_event_if.sv ====
// Trap event link
`timescale 1ns/1ps

interface trap_event_if
    import trap_pkg::*;
();
    // Interrupt taken this cycle.
    logic        ex_irq;
    // Synchronous trap taken this cycle.
    logic        ex_trap;
    // Cause code of the event.
    irq_cause_t  ex_cause;
    // PC to save in mepc.
    logic [31:1] ex_epc;
    // Latched pending interrupt lines.
    xlen_t       irq_ip;
    // Current mie register.
    xlen_t       irq_mie;
    // Current mstatus.MIE.
    logic        mstatus_mie;
    // Pending lines masked by mie, as read through mip.
    xlen_t       irq_ip_view;

    // Exception unit side.
    modport source (
        output ex_irq, ex_trap, ex_cause, ex_epc, irq_ip,
        input  irq_mie, mstatus_mie
    );

    // CSR file side.
    modport sink (
        input  ex_irq, ex_trap, ex_cause, ex_epc, irq_ip,
        output irq_mie, mstatus_mie, irq_ip_view
    );

endinterface

// ==== hw/exception_unit.sv ====
// Interrupt and trap dispatch
`timescale 1ns/1ps

module exception_unit
    import trap_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    // External interrupt lines 16 to 31.
    input  logic [31:16] irq,
    // Machine timer interrupt line.
    input  logic         timer_irq,
    // An instruction retires this cycle.
    input  logic         retire_valid,
    // PC of the retiring instruction.
    input  logic [31:1]  retire_pc,
    // Retiring instruction raises a trap.
    input  logic         trap_req,
    // Synchronous trap cause.
    input  logic [3:0]   trap_cause,
    trap_event_if.source ev,
    // Trap or interrupt taken, same cycle.
    output logic         exception
);

    // Raw interrupt lines placed at their numbers.
    xlen_t                irq_next;
    // Latched pending vector.
    xlen_t                pending;
    // Pending and enabled.
    xlen_t                masked;
    // Lowest enabled pending interrupt.
    irq_cause_t           irq_code;
    // Recent history of mstatus.MIE.
    logic [MIE_DELAY-1:0] mie_hist;
    // MIE has been stable long enough.
    logic                 irq_en;
    // Interrupt accepted this cycle.
    logic                 irq_take;

    // Line positions in the 32-bit vector.
    always_comb begin
        irq_next            = '0;
        irq_next[31:16]     = irq;
        irq_next[TIMER_IRQ] = timer_irq;
    end

    // One register stage on all interrupt lines.
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            pending <= irq_next;
        end
    end

    assign ev.irq_ip = pending;
    assign masked    = pending & ev.irq_mie;

    // Scan from the top so the lowest number wins.
    always_comb begin
        irq_code = '0;
        for (int i = 31; i >= 0; i--) begin
            if (masked[i]) begin
                irq_code = irq_cause_t'(i);
            end
        end
    end

    // Shift in MIE once per cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            mie_hist <= '0;
        end else begin
            mie_hist <= {mie_hist[MIE_DELAY-2:0], ev.mstatus_mie};
        end
    end

    // Set now and at each of the last MIE_DELAY edges.
    assign irq_en   = ev.mstatus_mie && (&mie_hist);
    // Interrupts only land on a retiring instruction.
    assign irq_take = irq_en && (|masked) && retire_valid;

    // Interrupt wins over a synchronous trap.
    assign ev.ex_irq   = irq_take;
    assign ev.ex_trap  = trap_req && !irq_take;
    assign ev.ex_cause = irq_take ? irq_code : {1'b0, trap_cause};
    // Both kinds save the retiring PC.
    assign ev.ex_epc   = retire_pc;

    assign exception = ev.ex_irq || ev.ex_trap;

endmodule

// ==== hw/machine_csrs.sv ====
// Machine-mode CSR file
`timescale 1ns/1ps

module machine_csrs
    import trap_pkg::*;
#(
    // Value of mhartid.
    parameter xlen_t hartid = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    csr_access_if.file  csr,
    trap_event_if.sink  ev,
    // Return from trap.
    input  logic        mret,
    // Trap vector base.
    output logic [31:2] tvec,
    // Saved exception PC.
    output logic [31:1] ret_epc
);

    // mstatus fields.
    logic        st_mie;
    logic        st_mpie;
    // misa enables.
    logic        isa_m;
    logic        isa_c;
    // Per-interrupt enables.
    xlen_t       mie_bits;
    // Trap vector, word aligned.
    logic [31:2] mtvec_base;
    // Scratch word for the handler.
    xlen_t       mscratch;
    // Exception PC, halfword aligned.
    logic [31:1] mepc_pc;
    // mcause fields.
    logic        mcause_irq;
    irq_cause_t  mcause_code;

    // Incoming write data.
    csr_word_u   wr;
    // Composed read words.
    csr_word_u   status_word;
    csr_word_u   isa_word;
    csr_word_u   cause_word;

    assign wr.raw = csr.wdata;

    // mstatus with only MIE and MPIE implemented.
    always_comb begin
        status_word              = '0;
        status_word.mstatus.mie  = st_mie;
        status_word.mstatus.mpie = st_mpie;
    end

    // RV32 base with optional M and C; A reads zero.
    always_comb begin
        isa_word        = '0;
        isa_word.misa.mxl = 2'b01;
        isa_word.misa.i = 1'b1;
        isa_word.misa.m = isa_m;
        isa_word.misa.c = isa_c;
    end

    // Flag in bit 31, code in the low bits.
    always_comb begin
        cause_word             = '0;
        cause_word.mcause.intr = mcause_irq;
        cause_word.mcause.code = mcause_code;
    end

    // mip shows pending lines that are enabled.
    assign ev.irq_ip_view = ev.irq_ip & mie_bits;

    // State for the exception unit and the fetch side.
    assign ev.irq_mie     = mie_bits;
    assign ev.mstatus_mie = st_mie;
    assign tvec           = mtvec_base;
    assign ret_epc        = mepc_pc;

    // Read decoder.
    always_comb begin
        csr.exists = 1'b1;
        csr.rdonly = 1'b0;
        csr.rdata  = '0;
        case (csr.addr)
            CSR_MSTATUS:  csr.rdata = status_word.raw;
            CSR_MISA:     csr.rdata = isa_word.raw;
            CSR_MIE:      csr.rdata = mie_bits;
            CSR_MTVEC:    csr.rdata = {mtvec_base, 2'b00};
            CSR_MIP:      csr.rdata = ev.irq_ip_view;
            CSR_MSCRATCH: csr.rdata = mscratch;
            CSR_MEPC:     csr.rdata = {mepc_pc, 1'b0};
            CSR_MCAUSE:   csr.rdata = cause_word.raw;
            // No delegation, no high status, no trap value.
            CSR_MEDELEG, CSR_MIDELEG, CSR_MSTATUSH, CSR_MTVAL: begin
                csr.rdata = '0;
            end
            // Identity words.
            CSR_MVENDORID, CSR_MCONFIGPTR: begin
                csr.rdonly = 1'b1;
            end
            CSR_MARCHID: begin
                csr.rdonly = 1'b1;
                csr.rdata  = ARCH_ID;
            end
            CSR_MIPID: begin
                csr.rdonly = 1'b1;
                csr.rdata  = IMPL_ID;
            end
            CSR_MHARTID: begin
                csr.rdonly = 1'b1;
                csr.rdata  = hartid;
            end
            default: csr.exists = 1'b0;
        endcase
    end

    // Register updates: trap first, then CSR write, then MRET.
    always_ff @(posedge clk) begin
        if (rst) begin
            st_mie      <= 1'b0;
            st_mpie     <= 1'b0;
            isa_m       <= HAS_M;
            isa_c       <= HAS_C;
            mie_bits    <= '0;
            mtvec_base  <= '0;
            mscratch    <= '0;
            mepc_pc     <= '0;
            mcause_irq  <= 1'b0;
            mcause_code <= '0;
        end else if (ev.ex_trap || ev.ex_irq) begin
            // Save state and mask interrupts.
            st_mpie     <= st_mie;
            st_mie      <= 1'b0;
            mepc_pc     <= ev.ex_epc;
            mcause_irq  <= ev.ex_irq;
            mcause_code <= ev.ex_cause;
        end else if (csr.we) begin
            // Read-only and zero CSRs fall through untouched.
            case (csr.addr)
                CSR_MSTATUS: begin
                    st_mie  <= wr.mstatus.mie;
                    st_mpie <= wr.mstatus.mpie;
                end
                CSR_MISA: begin
                    // Only supported extensions can be turned on.
                    isa_m <= HAS_M && wr.misa.m;
                    isa_c <= HAS_C && wr.misa.c;
                end
                CSR_MIE:      mie_bits   <= wr.raw;
                CSR_MTVEC:    mtvec_base <= wr.raw[31:2];
                CSR_MSCRATCH: mscratch   <= wr.raw;
                CSR_MEPC:     mepc_pc    <= wr.raw[31:1];
                CSR_MCAUSE: begin
                    mcause_irq  <= wr.mcause.intr;
                    mcause_code <= wr.mcause.code;
                end
                default: begin
                end
            endcase
        end else if (mret) begin
            // Restore interrupt enable.
            st_mie <= st_mpie;
        end
    end

endmodule

// ==== hw/trap_unit.sv ====
// Machine trap unit top level
`timescale 1ns/1ps

module trap_unit
    import trap_pkg::*;
#(
    // Value of mhartid.
    parameter xlen_t hartid = 32'h0000_0000
) (
    input  logic         clk,
    input  logic         rst,
    // CSR access.
    input  logic [11:0]  csr_addr,
    input  logic         csr_we,
    input  xlen_t        csr_wdata,
    output xlen_t        csr_rdata,
    output logic         csr_exists,
    output logic         csr_rdonly,
    // Retiring instruction.
    input  logic         retire_valid,
    input  logic [31:1]  retire_pc,
    input  logic         trap_req,
    input  logic [3:0]   trap_cause,
    input  logic         mret,
    // Interrupt lines.
    input  logic [31:16] irq,
    input  logic         timer_irq,
    // Redirect information.
    output logic         exception,
    output logic [31:2]  tvec,
    output logic [31:1]  ret_epc
);

    csr_access_if csr ();
    trap_event_if ev ();

    // CSR pins onto the access port.
    assign csr.addr   = csr_addr;
    assign csr.we     = csr_we;
    assign csr.wdata  = csr_wdata;
    assign csr_rdata  = csr.rdata;
    assign csr_exists = csr.exists;
    assign csr_rdonly = csr.rdonly;

    // Interrupt selection and dispatch.
    exception_unit exc0 (
        .clk          (clk),
        .rst          (rst),
        .irq          (irq),
        .timer_irq    (timer_irq),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .trap_req     (trap_req),
        .trap_cause   (trap_cause),
        .ev           (ev.source),
        .exception    (exception)
    );

    // Register file.
    machine_csrs #(
        .hartid (hartid)
    ) csrs0 (
        .clk     (clk),
        .rst     (rst),
        .csr     (csr.file),
        .ev      (ev.sink),
        .mret    (mret),
        .tvec    (tvec),
        .ret_epc (ret_epc)
    );

endmodule

// ==== test/trap_unit_properties.sv ====
// Dispatch rule assertions
`timescale 1ns/1ps

module trap_unit_properties (
    input logic clk,
    input logic rst,
    input logic ex_irq,
    input logic ex_trap,
    input logic retire_valid,
    input logic mstatus_mie
);

    // Interrupt and trap are exclusive.
    assert property (@(posedge clk) disable iff (rst) !(ex_irq && ex_trap))
        else $error("interrupt and trap dispatched together");

    // Interrupts land on a retiring instruction.
    assert property (@(posedge clk) disable iff (rst) ex_irq |-> retire_valid)
        else $error("interrupt taken without retire_valid");

    // MIE set now and at the two edges before.
    assert property (@(posedge clk) disable iff (rst)
        ex_irq |-> mstatus_mie && $past(mstatus_mie, 1) && $past(mstatus_mie, 2))
        else $error("interrupt taken before the MIE delay ran out");

endmodule

bind exception_unit trap_unit_properties props0 (
    .clk          (clk),
    .rst          (rst),
    .ex_irq       (ev.ex_irq),
    .ex_trap      (ev.ex_trap),
    .retire_valid (retire_valid),
    .mstatus_mie  (ev.mstatus_mie)
);

// ==== test/trap_unit_tb.sv ====
// Trap unit testbench
`timescale 1ns/1ps

module trap_unit_tb
    import trap_pkg::*;
();

    // Hart number given to the DUT.
    localparam xlen_t HART_ID = 32'h0000_0003;
    // Several times the length of all tests together.
    localparam int MAX_CYCLES = 400;

    logic         clk;
    logic         rst;
    logic         csr_we;
    logic         csr_exists;
    logic         csr_rdonly;
    logic         retire_valid;
    logic         trap_req;
    logic         mret;
    logic         timer_irq;
    logic         exception;
    logic [11:0]  csr_addr;
    xlen_t        csr_wdata;
    xlen_t        csr_rdata;
    logic [31:1]  retire_pc;
    logic [31:1]  ret_epc;
    logic [3:0]   trap_cause;
    logic [31:16] irq;
    logic [31:2]  tvec;
    integer       seed;
    int           cycles;
    int           checks;
    int           errors;
    int           tests;
    int           test_errors;
    string        test_name;

    trap_unit #(.hartid(HART_ID)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Run limit.
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, tests did not complete", cycles);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_word(input string what, input xlen_t exp, input xlen_t act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            test_errors = test_errors + 1;
            $display("FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        check_word(what, xlen_t'(exp), xlen_t'(act));
    endtask

    task automatic check_cause(input string what, input irq_cause_t exp, input irq_cause_t act);
        check_word(what, xlen_t'(exp), xlen_t'(act));
    endtask

    // RV32 misa with I and the given M and C bits.
    function automatic xlen_t misa_word(logic m, logic c);
        csr_word_u w;
        w = '0;
        w.misa.mxl = 2'b01;
        w.misa.i = 1'b1;
        w.misa.m = m;
        w.misa.c = c;
        return w.raw;
    endfunction

    // mstatus with only MIE and MPIE.
    function automatic xlen_t status_word(logic mie, logic mpie);
        csr_word_u w;
        w = '0;
        w.mstatus.mie = mie;
        w.mstatus.mpie = mpie;
        return w.raw;
    endfunction

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests = tests + 1;
        if (test_errors == 0) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: %0d errors", test_name, test_errors);
        end
    endtask

    // Write lands on the rising edge inside the strobe.
    task automatic csr_write(input logic [11:0] addr, input xlen_t data);
        @(negedge clk);
        csr_addr = addr;
        csr_wdata = data;
        csr_we = 1'b1;
        @(negedge clk);
        csr_we = 1'b0;
    endtask

    // Read data settles within the low phase.
    task automatic csr_read(input logic [11:0] addr, output csr_word_u w);
        @(negedge clk);
        csr_addr = addr;
        #1;
        w.raw = csr_rdata;
    endtask

    // One trapping instruction, checked in its own cycle.
    task automatic retire_trap(input xlen_t pc, input logic [3:0] cause);
        @(negedge clk);
        retire_valid = 1'b1;
        retire_pc = pc[31:1];
        trap_req = 1'b1;
        trap_cause = cause;
        #1;
        check_flag("exception", 1'b1, exception);
        @(negedge clk);
        retire_valid = 1'b0;
        trap_req = 1'b0;
    endtask

    // Poll once per cycle until exception rises.
    task automatic wait_exception();
        while (exception !== 1'b1) begin
            @(negedge clk);
            #1;
        end
    endtask

    task automatic identity_and_reset();
        csr_word_u w;
        begin_test("identity");
        csr_read(CSR_MHARTID, w);
        check_word("mhartid", HART_ID, w.raw);
        csr_read(CSR_MARCHID, w);
        check_word("marchid", ARCH_ID, w.raw);
        csr_read(CSR_MIPID, w);
        check_word("mipid", IMPL_ID, w.raw);
        check_word("mipid divider latency", 32'd2, {26'd0, w.raw[21:16]});
        csr_read(CSR_MISA, w);
        check_word("misa", misa_word(1'b1, 1'b1), w.raw);
        csr_read(CSR_MVENDORID, w);
        check_word("mvendorid", 32'd0, w.raw);
        check_flag("mvendorid rdonly", 1'b1, csr_rdonly);
        csr_read(CSR_MIE, w);
        check_word("mie", 32'd0, w.raw);
        csr_read(CSR_MSCRATCH, w);
        check_word("mscratch", 32'd0, w.raw);
        csr_read(CSR_MEPC, w);
        check_word("mepc", 32'd0, w.raw);
        csr_read(12'h7c0, w);
        check_flag("unlisted exists", 1'b0, csr_exists);
        end_test();
    endtask

    task automatic write_and_read_back();
        csr_word_u w;
        xlen_t value;
        begin_test("write_read");
        value = $random(seed);
        csr_write(CSR_MSCRATCH, value);
        csr_read(CSR_MSCRATCH, w);
        check_word("mscratch", value, w.raw);
        check_flag("mscratch exists", 1'b1, csr_exists);
        check_flag("mscratch rdonly", 1'b0, csr_rdonly);
        csr_write(CSR_MTVEC, 32'h8000_0103);
        csr_read(CSR_MTVEC, w);
        check_word("mtvec", 32'h8000_0100, w.raw);
        csr_write(CSR_MEPC, 32'h1234_5677);
        csr_read(CSR_MEPC, w);
        check_word("mepc", 32'h1234_5676, w.raw);
        csr_write(CSR_MHARTID, ~HART_ID);
        csr_read(CSR_MHARTID, w);
        check_word("mhartid after write", HART_ID, w.raw);
        csr_write(CSR_MISA, misa_word(1'b1, 1'b0));
        csr_read(CSR_MISA, w);
        check_word("misa without C", misa_word(1'b1, 1'b0), w.raw);
        // Bit 0 asks for A, which the hardware lacks.
        csr_write(CSR_MISA, misa_word(1'b1, 1'b1) | 32'h1);
        csr_read(CSR_MISA, w);
        check_word("misa with A request", misa_word(1'b1, 1'b1), w.raw);
        check_flag("misa A", 1'b0, w.misa.a);
        end_test();
    endtask

    task automatic sync_trap();
        csr_word_u w;
        xlen_t pc;
        begin_test("sync_trap");
        pc = $random(seed);
        csr_write(CSR_MTVEC, 32'h0000_2000);
        csr_write(CSR_MSTATUS, status_word(1'b1, 1'b0));
        retire_trap(pc, 4'd11);
        check_word("tvec", 32'h0000_2000, {tvec, 2'b00});
        csr_read(CSR_MEPC, w);
        check_word("mepc", {pc[31:1], 1'b0}, w.raw);
        csr_read(CSR_MCAUSE, w);
        check_flag("mcause flag", 1'b0, w.mcause.intr);
        check_cause("mcause code", 5'd11, w.mcause.code);
        csr_read(CSR_MSTATUS, w);
        check_word("mstatus", status_word(1'b0, 1'b1), w.raw);
        end_test();
    endtask

    task automatic irq_priority();
        csr_word_u w;
        begin_test("irq_priority");
        csr_write(CSR_MIE, (32'h1 << TIMER_IRQ) | (32'h1 << 20));
        csr_write(CSR_MSTATUS, status_word(1'b1, 1'b0));
        @(negedge clk);
        irq[20] = 1'b1;
        timer_irq = 1'b1;
        retire_valid = 1'b1;
        #1;
        wait_exception();
        @(negedge clk);
        retire_valid = 1'b0;
        timer_irq = 1'b0;
        csr_read(CSR_MCAUSE, w);
        check_flag("first flag", 1'b1, w.mcause.intr);
        check_cause("first code", irq_cause_t'(TIMER_IRQ), w.mcause.code);
        // Line 20 alone is left.
        csr_write(CSR_MIE, 32'h1 << 20);
        csr_write(CSR_MSTATUS, status_word(1'b1, 1'b0));
        @(negedge clk);
        retire_valid = 1'b1;
        #1;
        wait_exception();
        @(negedge clk);
        retire_valid = 1'b0;
        irq = '0;
        csr_read(CSR_MCAUSE, w);
        check_flag("second flag", 1'b1, w.mcause.intr);
        check_cause("second code", 5'd20, w.mcause.code);
        end_test();
    endtask

    task automatic masked_irq();
        csr_word_u w;
        xlen_t lines;
        xlen_t enables;
        logic seen;
        int i;
        begin_test("masked");
        lines = (32'h1 << 20) | (32'h1 << 17);
        enables = (32'h1 << 20) | (32'h1 << 16);
        seen = 1'b0;
        csr_write(CSR_MSTATUS, status_word(1'b0, 1'b0));
        csr_write(CSR_MIE, enables);
        @(negedge clk);
        irq = lines[31:16];
        retire_valid = 1'b1;
        for (i = 0; i < 10; i++) begin
            #1;
            seen = seen | exception;
            @(negedge clk);
        end
        check_flag("exception while masked", 1'b0, seen);
        csr_read(CSR_MIP, w);
        check_word("mip", lines & enables, w.raw);
        @(negedge clk);
        irq = '0;
        retire_valid = 1'b0;
        end_test();
    endtask

    task automatic mret_restore();
        csr_word_u w;
        xlen_t pc;
        begin_test("mret");
        pc = $random(seed);
        csr_write(CSR_MIE, 32'd0);
        csr_write(CSR_MSTATUS, status_word(1'b1, 1'b0));
        retire_trap(pc, 4'd2);
        csr_read(CSR_MSTATUS, w);
        check_word("mstatus after trap", status_word(1'b0, 1'b1), w.raw);
        @(negedge clk);
        mret = 1'b1;
        @(negedge clk);
        mret = 1'b0;
        csr_read(CSR_MSTATUS, w);
        check_flag("mstatus.MIE after mret", 1'b1, w.mstatus.mie);
        check_word("ret_epc", {pc[31:1], 1'b0}, {ret_epc, 1'b0});
        csr_read(CSR_MEPC, w);
        check_word("mepc", {pc[31:1], 1'b0}, w.raw);
        end_test();
    endtask

    initial begin
        seed = 59;
        cycles = 0;
        checks = 0;
        errors = 0;
        tests = 0;
        test_errors = 0;
        rst = 1'b1;
        csr_addr = '0;
        csr_we = 1'b0;
        csr_wdata = '0;
        retire_valid = 1'b0;
        retire_pc = '0;
        trap_req = 1'b0;
        trap_cause = '0;
        mret = 1'b0;
        irq = '0;
        timer_irq = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        identity_and_reset();
        write_and_read_back();
        sync_trap();
        irq_priority();
        masked_irq();
        mret_restore();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hw/trap_pkg.sv
hw/csr_access_if.sv
hw/trap_event_if.sv
hw/exception_unit.sv
hw/machine_csrs.sv
hw/trap_unit.sv
test/trap_unit_properties.sv
test/trap_unit_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := trap_unit_tb
FILELIST   := compile.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_TEXT  := test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
